/* scc_top.f */
+incdir+src
src/scc_pkg.sv
src/scc_bus_decode.sv
src/scc_wave_ram.sv
src/scc_pitch_counter.sv
src/scc_voice.sv
src/scc_mixer.sv
src/scc_top.sv
bench/scc_tb.sv

/* Makefile */
# Verilator build and run for the wavetable sound generator

VERILATOR ?= verilator
TOP       ?= scc_tb
FILELIST  ?= scc_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the log decides the result, not the simulator exit code
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q -F -x '** PASS **' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/scc_tb.sv */
`default_nettype none

`include "scc_defs.svh"

module scc_tb
    import scc_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_half = 50;
    localparam int drive_dly = 5;
    localparam int settle_limit = 12;
    localparam int nv = `SCC_NUM_VOICES;
    localparam int depth = `SCC_WAVE_DEPTH;
    localparam int wave_win = `SCC_WAVE_WIN;
    localparam int freq_base = `SCC_FREQ_BASE;
    localparam int vol_base = `SCC_VOL_BASE;
    localparam int en_addr = `SCC_EN_ADDR;

    logic        emuclk;
    logic        rst_n;
    logic        mclk_pcen_n;
    logic        wrrq;
    logic        rdrq;
    logic [7:0]  addr;
    logic [7:0]  db_wr;
    logic [7:0]  db_rd;
    sound_t      sound;
    logic [31:0] lcg_state;
    logic [7:0]  wave_exp [nv][depth];
    int          test_errors;
    int          total_errors;
    int          tests_run;
    int          tests_failed;
    int          checks;
    string       test_name;

    scc_top DUT (
        .i_emuclk      (emuclk),
        .i_rst_n       (rst_n),
        .i_mclk_pcen_n (mclk_pcen_n),
        .i_wrrq        (wrrq),
        .i_rdrq        (rdrq),
        .i_addr        (addr),
        .i_db          (db_wr),
        .o_db          (db_rd),
        .o_sound       (sound)
    );

    initial begin
        emuclk = 1'b0;
        forever begin
            #clk_half emuclk = ~emuclk;
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    // inputs change just after the rising edge
    task automatic step_clock();
        @(posedge emuclk);
        #drive_dly;
    endtask

    function automatic logic [7:0] lcg_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    // sample times volume shifted right by 4
    function automatic int expected_scaled(logic [7:0] wave_byte, int vol);
        int s;
        s = int'($signed(wave_byte));
        return (s * vol) >>> 4;
    endfunction

    task automatic check_value(string what, int expected, int actual);
        checks++;
        assert (actual == expected) else begin
            $display("mismatch %s %s: expected %0d actual %0d",
                     test_name, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic begin_test(string name);
        test_name = name;
        test_errors = 0;
    endtask

    task automatic finish_test();
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s passed", test_name);
        end else begin
            $display("test %s failed with %0d errors", test_name, test_errors);
            tests_failed++;
        end
    endtask

    // write lands two edges after the strobe
    task automatic write_reg(logic [7:0] a, logic [7:0] d);
        wrrq = 1'b1;
        addr = a;
        db_wr = d;
        step_clock();
        wrrq = 1'b0;
        step_clock();
    endtask

    task automatic read_reg(logic [7:0] a, output logic [7:0] d);
        rdrq = 1'b1;
        addr = a;
        step_clock();
        rdrq = 1'b0;
        for (int n = 0; n < 2; n++) begin
            step_clock();
        end
        d = db_rd;
    endtask

    task automatic fill_wave(int voice, logic [7:0] value);
        for (int i = 0; i < depth; i++) begin
            write_reg(8'(voice * wave_win + i), value);
        end
    endtask

    task automatic wait_sound(int expected, string what);
        int n;
        n = 0;
        while (int'(sound) != expected && n < settle_limit) begin
            step_clock();
            n++;
        end
        check_value(what, expected, int'(sound));
    endtask

    // count cycles until o_sound moves
    task automatic wait_step(int limit, output int cycles);
        sound_t start;
        bit     seen;
        start = sound;
        cycles = 0;
        seen = 1'b0;
        while (!seen && cycles < limit) begin
            step_clock();
            cycles++;
            seen = (sound != start);
        end
        assert (seen) else begin
            $display("%s: o_sound did not change within %0d cycles", test_name, limit);
            test_errors++;
        end
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic reset_state_check();
        begin_test("reset_state");
        check_value("o_sound", 0, int'(sound));
        check_value("o_db", 0, int'(db_rd));
        finish_test();
    endtask

    task automatic wave_readback();
        logic [7:0] got;
        begin_test("wave_readback");
        for (int v = 0; v < nv; v++) begin
            for (int i = 0; i < depth; i++) begin
                wave_exp[v][i] = lcg_byte();
                write_reg(8'(v * wave_win + i), wave_exp[v][i]);
            end
        end
        // all windows written first, so crosstalk would show here
        for (int v = 0; v < nv; v++) begin
            for (int i = 0; i < depth; i++) begin
                read_reg(8'(v * wave_win + i), got);
                check_value($sformatf("voice %0d byte %0d", v, i),
                            int'(wave_exp[v][i]), int'(got));
            end
        end
        finish_test();
    endtask

    task automatic volume_scaling();
        begin_test("volume_scaling");
        fill_wave(0, 8'h40);
        write_reg(8'(vol_base), 8'd15);
        write_reg(8'(en_addr), 8'h01);
        wait_sound(expected_scaled(8'h40, 15), "fill 40 vol 15");
        write_reg(8'(vol_base), 8'd8);
        wait_sound(expected_scaled(8'h40, 8), "fill 40 vol 8");
        write_reg(8'(vol_base), 8'd15);
        fill_wave(0, 8'h80);
        wait_sound(expected_scaled(8'h80, 15), "fill 80 vol 15");
        finish_test();
    endtask

    task automatic enable_gating();
        begin_test("enable_gating");
        write_reg(8'(en_addr), 8'h00);
        wait_sound(0, "disabled");
        write_reg(8'(en_addr), 8'h01);
        wait_sound(expected_scaled(8'h80, 15), "enabled again");
        finish_test();
    endtask

    task automatic voice_mixing();
        logic [7:0] fills [4];
        int         vols [4];
        int         expected;
        begin_test("voice_mixing");
        fills = '{8'h30, 8'hA0, 8'h7F, 8'hC8};
        vols = '{15, 10, 7, 12};
        expected = 0;
        for (int v = 0; v < nv; v++) begin
            fill_wave(v, fills[v]);
            write_reg(8'(vol_base + v), 8'(vols[v]));
            expected += expected_scaled(fills[v], vols[v]);
        end
        write_reg(8'(en_addr), 8'((1 << nv) - 1));
        wait_sound(expected, "sum of voices");
        finish_test();
    endtask

    task automatic pitch_period();
        int freqs [5];
        int f;
        int idx;
        int cycles;
        begin_test("pitch_period");
        // the last value needs the high nibble
        freqs = '{0, 1, 5, 20, 261};
        write_reg(8'(en_addr), 8'h01);
        write_reg(8'(vol_base), 8'd15);
        for (int i = 0; i < depth; i++) begin
            write_reg(8'(i), 8'(4 * i));
        end
        for (int t = 0; t < 5; t++) begin
            f = freqs[t];
            write_reg(8'(freq_base), 8'(f));
            write_reg(8'(freq_base + 1), 8'(f >> 8));
            // a step from before the write may still be in the pipeline
            wait_step(2 * (f + 1) + 8, cycles);
            wait_step(2 * (f + 1) + 8, cycles);
            idx = -1;
            for (int i = 0; i < depth; i++) begin
                if (expected_scaled(8'(4 * i), 15) == int'(sound)) begin
                    idx = i;
                end
            end
            assert (idx >= 0) else begin
                $display("%s: o_sound %0d is not a ramp value", test_name, sound);
                test_errors++;
            end
            for (int s = 0; s < 5; s++) begin
                wait_step(f + 9, cycles);
                check_value($sformatf("spacing at freq %0d", f), f + 1, cycles);
                idx = (idx + 1) % depth;
                check_value($sformatf("ramp value at freq %0d", f),
                            expected_scaled(8'(4 * idx), 15), int'(sound));
            end
        end
        finish_test();
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        lcg_state = 32'h8216_a14f;
        rst_n = 1'b0;
        mclk_pcen_n = 1'b0;
        wrrq = 1'b0;
        rdrq = 1'b0;
        addr = 8'h00;
        db_wr = 8'h00;
        test_errors = 0;
        total_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        checks = 0;
        test_name = "";
        repeat (10) step_clock();
        rst_n = 1'b1;
        step_clock();
        reset_state_check();
        wave_readback();
        volume_scaling();
        enable_gating();
        voice_mixing();
        pitch_period();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, checks, total_errors);
        if (total_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src/scc_top.sv */
`default_nettype none

`include "scc_defs.svh"

module scc_top
    import scc_pkg::*;
(
    input  wire logic       i_emuclk,
    input  wire logic       i_rst_n,
    input  wire logic       i_mclk_pcen_n,
    input  wire logic       i_wrrq,
    input  wire logic       i_rdrq,
    input  wire logic [7:0] i_addr,
    input  wire logic [7:0] i_db,
    output logic [7:0]      o_db,
    output sound_t          o_sound
);

    voice_ctl_t ctl     [`SCC_NUM_VOICES];
    logic [7:0] rd_q    [`SCC_NUM_VOICES];
    sample_t    samples [`SCC_NUM_VOICES];

    //////////////////////////////
    // cpu bus
    //////////////////////////////

    scc_bus_decode u_bus_decode (
        .i_emuclk      (i_emuclk),
        .i_rst_n       (i_rst_n),
        .i_mclk_pcen_n (i_mclk_pcen_n),
        .i_wrrq        (i_wrrq),
        .i_rdrq        (i_rdrq),
        .i_addr        (i_addr),
        .i_db          (i_db),
        .i_rd_q        (rd_q),
        .o_ctl         (ctl),
        .o_db          (o_db)
    );

    //////////////////////////////
    // voices
    //////////////////////////////

    for (genvar k = 0; k < `SCC_NUM_VOICES; k++) begin : g_voice
        scc_voice u_voice (
            .i_emuclk      (i_emuclk),
            .i_rst_n       (i_rst_n),
            .i_mclk_pcen_n (i_mclk_pcen_n),
            .i_ctl         (ctl[k]),
            .o_rd_q        (rd_q[k]),
            .o_sample      (samples[k])
        );
    end

    // output stage
    scc_mixer u_mixer (
        .i_emuclk      (i_emuclk),
        .i_rst_n       (i_rst_n),
        .i_mclk_pcen_n (i_mclk_pcen_n),
        .i_samples     (samples),
        .o_sound       (o_sound)
    );

endmodule

`default_nettype wire

/* src/scc_mixer.sv */
`default_nettype none

`include "scc_defs.svh"

module scc_mixer
    import scc_pkg::*;
(
    input  wire logic    i_emuclk,
    input  wire logic    i_rst_n,
    input  wire logic    i_mclk_pcen_n,
    input  wire sample_t i_samples [`SCC_NUM_VOICES],
    output sound_t       o_sound
);

    sound_t sum;

    //////////////////////////////
    // sum of voices
    //////////////////////////////

    // samples are signed, the cast extends the sign
    always_comb begin
        sum = '0;
        for (int k = 0; k < `SCC_NUM_VOICES; k++) begin
            sum = sum + sound_t'(i_samples[k]);
        end
    end

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            o_sound <= '0;
        end else if (!i_mclk_pcen_n) begin
            o_sound <= sum;
        end
    end

endmodule

`default_nettype wire

/* src/scc_voice.sv */
`default_nettype none

module scc_voice
    import scc_pkg::*;
(
    input  wire logic       i_emuclk,
    input  wire logic       i_rst_n,
    input  wire logic       i_mclk_pcen_n,
    input  wire voice_ctl_t i_ctl,
    output logic [7:0]      o_rd_q,
    output sample_t         o_sample
);

    vol_t              vol;
    logic              en;
    wave_idx_t         pitch_idx;
    wave_idx_t         ram_addr;
    logic [7:0]        ram_q;
    logic signed [12:0] product;

    //////////////////////////////
    // wave table and pitch
    //////////////////////////////

    // cpu access takes the ram for one cycle
    assign ram_addr = (i_ctl.wave_re || i_ctl.wave_we) ? i_ctl.addr : pitch_idx;

    scc_wave_ram u_wave_ram (
        .i_emuclk      (i_emuclk),
        .i_mclk_pcen_n (i_mclk_pcen_n),
        .i_we          (i_ctl.wave_we),
        .i_addr        (ram_addr),
        .i_d           (i_ctl.data),
        .o_q           (ram_q)
    );

    scc_pitch_counter u_pitch (
        .i_emuclk      (i_emuclk),
        .i_rst_n       (i_rst_n),
        .i_mclk_pcen_n (i_mclk_pcen_n),
        .i_freq_lo_we  (i_ctl.freq_lo_we),
        .i_freq_hi_we  (i_ctl.freq_hi_we),
        .i_data        (i_ctl.data),
        .o_idx         (pitch_idx)
    );

    assign o_rd_q = ram_q;

    //////////////////////////////
    // volume and enable
    //////////////////////////////

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            vol <= '0;
            en  <= 1'b0;
        end else if (!i_mclk_pcen_n) begin
            if (i_ctl.vol_we) begin
                vol <= i_ctl.data[3:0];
            end
            if (i_ctl.en_we) begin
                en <= i_ctl.en_bit;
            end
        end
    end

    //////////////////////////////
    // scaled output
    //////////////////////////////

    // volume is unsigned, so pad a zero sign bit
    assign product = $signed(ram_q) * $signed({1'b0, vol});

    // bits 11:4 are the product shifted right by 4, range -120..119
    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            o_sample <= '0;
        end else if (!i_mclk_pcen_n) begin
            o_sample <= en ? product[11:4] : '0;
        end
    end

endmodule

`default_nettype wire

/* src/scc_pitch_counter.sv */
`default_nettype none

module scc_pitch_counter
    import scc_pkg::*;
(
    input  wire logic       i_emuclk,
    input  wire logic       i_rst_n,
    input  wire logic       i_mclk_pcen_n,
    input  wire logic       i_freq_lo_we,
    input  wire logic       i_freq_hi_we,
    input  wire logic [7:0] i_data,
    output wave_idx_t       o_idx
);

    freq_t freq;
    freq_t freq_next;
    freq_t period_cnt;

    // register value after this cycle's byte writes
    always_comb begin
        freq_next = freq;
        if (i_freq_lo_we) begin
            freq_next[7:0] = i_data;
        end
        if (i_freq_hi_we) begin
            freq_next[11:8] = i_data[3:0];
        end
    end

    //////////////////////////////
    // period counter
    //////////////////////////////

    // counts freq down to 0, so one step takes freq + 1 clocks
    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            freq       <= '0;
            period_cnt <= '0;
            o_idx      <= '0;
        end else if (!i_mclk_pcen_n) begin
            freq <= freq_next;
            if (i_freq_lo_we || i_freq_hi_we) begin
                // restart the period, index stays put
                period_cnt <= freq_next;
            end else if (period_cnt == '0) begin
                period_cnt <= freq;
                o_idx      <= o_idx + 1'b1;
            end else begin
                period_cnt <= period_cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/scc_wave_ram.sv */
`default_nettype none

`include "scc_defs.svh"

module scc_wave_ram
    import scc_pkg::*;
(
    input  wire logic       i_emuclk,
    input  wire logic       i_mclk_pcen_n,
    input  wire logic       i_we,
    input  wire wave_idx_t  i_addr,
    input  wire logic [7:0] i_d,
    output logic [7:0]      o_q
);

    logic [7:0] mem [`SCC_WAVE_DEPTH];

    //////////////////////////////
    // write port
    //////////////////////////////

    always_ff @(posedge i_emuclk) begin
        if (!i_mclk_pcen_n && i_we) begin
            mem[i_addr] <= i_d;
        end
    end

    //////////////////////////////
    // read port
    //////////////////////////////

    // the bus data shows on the output while a write is in progress
    assign o_q = i_we ? i_d : mem[i_addr];

endmodule

`default_nettype wire

/* src/scc_bus_decode.sv */
`default_nettype none

`include "scc_defs.svh"

module scc_bus_decode
    import scc_pkg::*;
(
    input  wire logic       i_emuclk,
    input  wire logic       i_rst_n,
    input  wire logic       i_mclk_pcen_n,
    input  wire logic       i_wrrq,
    input  wire logic       i_rdrq,
    input  wire logic [7:0] i_addr,
    input  wire logic [7:0] i_db,
    input  wire logic [7:0] i_rd_q [`SCC_NUM_VOICES],
    output voice_ctl_t      o_ctl [`SCC_NUM_VOICES],
    output logic [7:0]      o_db
);

    logic                       wr_q;
    logic                       rd_q;
    logic [7:0]                 addr_q;
    logic [7:0]                 data_q;
    logic [`SCC_NUM_VOICES-1:0] win_hit;
    logic [7:0]                 rd_data;

    //////////////////////////////
    // bus capture
    //////////////////////////////

    // strobes live for one enabled cycle
    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            wr_q <= 1'b0;
            rd_q <= 1'b0;
        end else if (!i_mclk_pcen_n) begin
            wr_q <= i_wrrq;
            rd_q <= i_rdrq;
        end
    end

    always_ff @(posedge i_emuclk) begin
        if (!i_mclk_pcen_n && (i_wrrq || i_rdrq)) begin
            addr_q <= i_addr;
            data_q <= i_db;
        end
    end

    //////////////////////////////
    // address decode
    //////////////////////////////

    for (genvar k = 0; k < `SCC_NUM_VOICES; k++) begin : g_voice
        localparam int wave_lo  = k * `SCC_WAVE_WIN;
        localparam int wave_hi  = wave_lo + `SCC_WAVE_DEPTH;
        localparam int freq_lo  = `SCC_FREQ_BASE + 2 * k;
        localparam int vol_addr = `SCC_VOL_BASE + k;

        assign win_hit[k] = (int'(addr_q) >= wave_lo) && (int'(addr_q) < wave_hi);

        // window is aligned, so the low bits index the wave
        assign o_ctl[k] = '{
            wave_we:    wr_q && win_hit[k],
            wave_re:    rd_q && win_hit[k],
            freq_lo_we: wr_q && (int'(addr_q) == freq_lo),
            freq_hi_we: wr_q && (int'(addr_q) == freq_lo + 1),
            vol_we:     wr_q && (int'(addr_q) == vol_addr),
            en_we:      wr_q && (addr_q == `SCC_EN_ADDR),
            en_bit:     data_q[k],
            addr:       addr_q[4:0],
            data:       data_q
        };
    end

    //////////////////////////////
    // read data
    //////////////////////////////

    // unmapped reads return 0
    always_comb begin
        rd_data = 8'h00;
        for (int k = 0; k < `SCC_NUM_VOICES; k++) begin
            if (win_hit[k]) begin
                rd_data = i_rd_q[k];
            end
        end
    end

    always_ff @(posedge i_emuclk) begin
        if (!i_rst_n) begin
            o_db <= 8'h00;
        end else if (!i_mclk_pcen_n && rd_q) begin
            o_db <= rd_data;
        end
    end

endmodule

`default_nettype wire

/* src/scc_pkg.sv */
`default_nettype none

`include "scc_defs.svh"

package scc_pkg;

    // raw wave byte, two's complement
    typedef logic signed [7:0] sample_t;

    typedef logic [3:0] vol_t;

    // period in enabled clocks, minus one
    typedef logic [11:0] freq_t;

    typedef logic [$clog2(`SCC_WAVE_DEPTH)-1:0] wave_idx_t;

    // mixed output, room for four full-scale voices
    typedef logic signed [10:0] sound_t;

    // per-voice strobes from the bus decoder
    typedef struct packed {
        logic      wave_we;
        logic      wave_re;
        logic      freq_lo_we;
        logic      freq_hi_we;
        logic      vol_we;
        logic      en_we;
        logic      en_bit;
        wave_idx_t addr;
        logic [7:0] data;
    } voice_ctl_t;

endpackage

`default_nettype wire

/* src/scc_defs.svh */
`ifndef SCC_DEFS_SVH
`define SCC_DEFS_SVH

//////////////////////////////
// voice array
//////////////////////////////

// 1 to 4 voices fit, one wave window each
`define SCC_NUM_VOICES 3

// bytes in one wave table
`define SCC_WAVE_DEPTH 32

//////////////////////////////
// register map
//////////////////////////////

// voice k wave at k * window
`define SCC_WAVE_WIN 8'h20

// low byte at base + 2k, high nibble at base + 2k + 1
`define SCC_FREQ_BASE 8'h80

// volume of voice k at base + k
`define SCC_VOL_BASE 8'h8A

// bit k enables voice k
`define SCC_EN_ADDR 8'h8F

`endif
